// File: source/pe_simd_pkg.sv
package pe_simd_pkg;

    ///////////////////////////////
    // sizes
    ///////////////////////////////
    localparam int part_width     = 16;                  // one q1.15 part
    localparam int cplx_width     = 2 * part_width;      // re in upper half
    localparam int frac_bits      = 15;                  // q1.15 product shift
    localparam int reg_num        = 16;                  // complex registers
    localparam int reg_addr_width = $clog2(reg_num);
    localparam int prog_depth     = 32;                  // instruction words
    localparam int pc_width       = $clog2(prog_depth);

    // product of a 16 bit part with a 17 bit negated part
    localparam int prod_width     = 2 * part_width + 1;
    localparam int sum_width      = prod_width + 1;     // two products added

    localparam int alu_latency    = 3;                   // alu register stages
    // counter must hold latency+1 results in flight
    localparam int flight_width   = $clog2(alu_latency + 2);

    ///////////////////////////////
    // instruction word layout
    ///////////////////////////////
    localparam int inst_width     = 16;
    localparam int op_width       = 4;
    localparam int op_lsb         = 12;                  // opcode on top
    localparam int dst_lsb        = 8;
    localparam int src_a_lsb      = 4;
    localparam int src_b_lsb      = 0;

    typedef logic signed [part_width-1:0] part_t;        // q1.15 part
    typedef logic [cplx_width-1:0]        cplx_t;        // {re, im}
    typedef logic [reg_addr_width-1:0]    reg_addr_t;
    typedef logic [pc_width-1:0]          pc_t;
    typedef logic [inst_width-1:0]        inst_t;        // {op, dst, src_a, src_b}

    typedef enum logic [op_width-1:0] {
        nop  = 4'd0,
        add  = 4'd1,   // a + b
        sub  = 4'd2,   // a - b
        mul  = 4'd3,   // a * b
        cmul = 4'd4,   // a * conj(b)
        out  = 4'd5,   // emit a
        halt = 4'd6
    } opcode_t;

endpackage

// File: source/pe_ifs.sv
`timescale 1ns/10ps

// issue bus, control to data memory and alu
interface pe_issue_if;
    import pe_simd_pkg::*;

    logic      issue_v;   // one instruction leaves control
    opcode_t   op;
    reg_addr_t dst;
    reg_addr_t src_a;
    reg_addr_t src_b;

    modport control (output issue_v, output op, output dst, output src_a, output src_b);
    modport mem     (input src_a, input src_b);          // read addresses only
    modport alu     (input issue_v, input op, input dst);
endinterface

// result bus out of the alu
interface pe_wb_if;
    import pe_simd_pkg::*;

    logic      wb_v;      // write result to wb_dst
    logic      out_v;     // emit result on dout
    reg_addr_t wb_dst;
    cplx_t     wb_data;

    modport alu  (output wb_v, output out_v, output wb_dst, output wb_data);
    modport mem  (input wb_v, input wb_dst, input wb_data);
    modport ctrl (input wb_v, input out_v, input wb_dst);  // scoreboard and retire count
endinterface

// File: source/inst_mem.sv
`timescale 1ns/10ps

module inst_mem (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                busy,
    input  logic                inst_in_v,
    input  pe_simd_pkg::inst_t  inst_in,
    input  pe_simd_pkg::pc_t    pc,
    output pe_simd_pkg::inst_t  inst
);
    import pe_simd_pkg::*;

    inst_t mem [prog_depth];   // program store
    pc_t   ld_cnt;             // next load address
    logic  ld_en;

    // host loads only between runs
    assign ld_en = inst_in_v && !busy;

    ///////////////////////////////
    // load counter
    ///////////////////////////////
    always_ff @(posedge clk) begin
        if (reset || start) begin
            ld_cnt <= '0;              // next program starts at 0
        end else if (ld_en) begin
            ld_cnt <= ld_cnt + 1'b1;   // wraps after prog_depth words
        end
    end

    ///////////////////////////////
    // storage
    ///////////////////////////////
    always_ff @(posedge clk) begin
        if (ld_en) begin
            mem[ld_cnt] <= inst_in;
        end
    end

    // registered fetch, word at pc shows up next cycle
    always_ff @(posedge clk) begin
        inst <= mem[pc];
    end

endmodule

// File: source/pe_control.sv
`timescale 1ns/10ps

module pe_control (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  pe_simd_pkg::inst_t inst,
    output pe_simd_pkg::pc_t   pc,
    output logic               busy,
    output logic               done,
    pe_issue_if.control        issue,
    pe_wb_if.ctrl              wb
);
    import pe_simd_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,   // first word on its way out of inst_mem
        st_run,
        st_drain    // halt seen, waiting on the alu
    } state_t;

    state_t                  state;
    pc_t                     pc_q;         // address of the word now in inst
    logic [reg_num-1:0]      pending;      // scoreboard, one bit per register
    logic [reg_num-1:0]      pending_next;
    logic [reg_num-1:0]      set_mask;
    logic [reg_num-1:0]      clr_mask;
    logic [flight_width-1:0] in_flight;    // issued, not yet retired
    logic [flight_width-1:0] in_flight_next;

    opcode_t   dec_op;
    reg_addr_t dec_dst;
    reg_addr_t dec_src_a;
    reg_addr_t dec_src_b;
    logic      running;
    logic      is_arith;   // writes a register
    logic      uses_alu;
    logic      hazard;
    logic      issue_ok;
    logic      advance;    // move on to the next word
    logic      retire;

    ///////////////////////////////
    // decode and hazard check
    ///////////////////////////////
    always_comb begin
        dec_op    = opcode_t'(inst[op_lsb +: op_width]);
        dec_dst   = inst[dst_lsb +: reg_addr_width];
        dec_src_a = inst[src_a_lsb +: reg_addr_width];
        dec_src_b = inst[src_b_lsb +: reg_addr_width];
        running   = (state == st_run);
        is_arith  = dec_op inside {add, sub, mul, cmul};
        uses_alu  = is_arith || (dec_op == out);
        hazard    = pending[dec_src_a] | pending[dec_src_b] | pending[dec_dst];
        issue_ok  = running && uses_alu && !hazard;
        // nop steps on, halt stops the pc, a hazard holds it
        advance   = running && (dec_op != halt) && !(uses_alu && hazard);
    end

    assign pc = advance ? pc_q + 1'b1 : pc_q;   // next word to read

    assign issue.issue_v = issue_ok;
    assign issue.op      = dec_op;
    assign issue.dst     = dec_dst;
    assign issue.src_a   = dec_src_a;   // data_mem reads these every cycle
    assign issue.src_b   = dec_src_b;

    ///////////////////////////////
    // scoreboard and retire count
    ///////////////////////////////
    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        if (issue_ok && is_arith) begin
            set_mask[dec_dst] = 1'b1;
        end
        if (wb.wb_v) begin
            clr_mask[wb.wb_dst] = 1'b1;   // result lands in data_mem this cycle
        end
        pending_next = (pending & ~clr_mask) | set_mask;
    end

    assign retire         = wb.wb_v || wb.out_v;
    assign in_flight_next = in_flight + flight_width'(issue_ok) - flight_width'(retire);

    assign busy = (state != st_idle);

    ///////////////////////////////
    // run fsm
    ///////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            pc_q      <= '0;
            pending   <= '0;
            in_flight <= '0;
            done      <= 1'b0;
        end else begin
            done      <= 1'b0;   // single cycle pulse
            pending   <= pending_next;
            in_flight <= in_flight_next;
            if (advance) begin
                pc_q <= pc_q + 1'b1;
            end
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_fetch;
                        pc_q  <= '0;
                    end
                end
                st_fetch: state <= st_run;   // word 0 valid next cycle
                st_run: begin
                    if (dec_op == halt) begin
                        if (in_flight_next == '0) begin
                            state <= st_idle;   // nothing left, finish now
                            done  <= 1'b1;
                        end else begin
                            state <= st_drain;
                        end
                    end
                end
                st_drain: begin
                    if (in_flight_next == '0) begin
                        state <= st_idle;
                        done  <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: source/data_mem.sv
`timescale 1ns/10ps

module data_mem (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                busy,
    input  logic                din_v,
    input  pe_simd_pkg::cplx_t  din_pe,
    pe_issue_if.mem             issue,
    pe_wb_if.mem                wb,
    output pe_simd_pkg::cplx_t  rdata_a,
    output pe_simd_pkg::cplx_t  rdata_b
);
    import pe_simd_pkg::*;

    cplx_t     regs [reg_num];   // complex register file
    reg_addr_t ld_cnt;           // next load address
    logic      ld_en;

    // writeback wins, a load in the same cycle is dropped
    assign ld_en = din_v && !busy && !wb.wb_v;

    ///////////////////////////////
    // load counter
    ///////////////////////////////
    always_ff @(posedge clk) begin
        if (reset || start) begin
            ld_cnt <= '0;
        end else if (ld_en) begin
            ld_cnt <= ld_cnt + 1'b1;   // wraps at reg_num
        end
    end

    ///////////////////////////////
    // write port
    ///////////////////////////////
    always_ff @(posedge clk) begin
        if (wb.wb_v) begin
            regs[wb.wb_dst] <= wb.wb_data;   // alu result
        end else if (ld_en) begin
            regs[ld_cnt] <= din_pe;          // host operand
        end
    end

    ///////////////////////////////
    // read ports
    ///////////////////////////////
    // both addressed every cycle, operands valid one cycle after issue
    always_ff @(posedge clk) begin
        rdata_a <= regs[issue.src_a];
        rdata_b <= regs[issue.src_b];
    end

endmodule

// File: source/complex_alu.sv
`timescale 1ns/10ps

module complex_alu (
    input  logic               clk,
    input  logic               reset,
    pe_issue_if.alu            issue,
    input  pe_simd_pkg::cplx_t rdata_a,
    input  pe_simd_pkg::cplx_t rdata_b,
    pe_wb_if.alu               wb
);
    import pe_simd_pkg::*;

    ///////////////////////////////
    // issue delay, lines up with rdata
    ///////////////////////////////
    logic      v0;
    opcode_t   op0;
    reg_addr_t dst0;

    always_ff @(posedge clk) begin
        if (reset) begin
            v0 <= 1'b0;
        end else begin
            v0 <= issue.issue_v;
        end
        op0  <= issue.op;
        dst0 <= issue.dst;
    end

    ///////////////////////////////
    // stage 1, partial products
    ///////////////////////////////
    part_t                    a_re, a_im, b_re, b_im;
    logic signed [part_width:0] b_im_ext;   // 17 bits so -(-1.0) fits
    logic signed [part_width:0] b_im_x;     // conj for cmul
    logic signed [prod_width-1:0] p_rr, p_ii, p_ri, p_ir;
    cplx_t     a1, b1;
    logic      v1;
    opcode_t   op1;
    reg_addr_t dst1;

    assign a_re     = rdata_a[cplx_width-1 -: part_width];
    assign a_im     = rdata_a[part_width-1:0];
    assign b_re     = rdata_b[cplx_width-1 -: part_width];
    assign b_im     = rdata_b[part_width-1:0];
    assign b_im_ext = b_im;   // sign extend
    assign b_im_x   = (op0 == cmul) ? -b_im_ext : b_im_ext;

    always_ff @(posedge clk) begin
        if (reset) begin
            v1 <= 1'b0;
        end else begin
            v1 <= v0;
        end
        op1  <= op0;
        dst1 <= dst0;
        a1   <= rdata_a;   // kept for add, sub and out
        b1   <= rdata_b;
        p_rr <= a_re * b_re;
        p_ii <= a_im * b_im_x;
        p_ri <= a_re * b_im_x;
        p_ir <= a_im * b_re;
    end

    ///////////////////////////////
    // stage 2, sums
    ///////////////////////////////
    part_t lin_re, lin_im;   // wrapping 16 bit results
    logic signed [sum_width-1:0] s2_re, s2_im;
    logic      v2;
    opcode_t   op2;
    reg_addr_t dst2;

    always_comb begin
        case (op1)
            add: begin
                lin_re = part_t'(a1[cplx_width-1 -: part_width])
                       + part_t'(b1[cplx_width-1 -: part_width]);
                lin_im = part_t'(a1[part_width-1:0]) + part_t'(b1[part_width-1:0]);
            end
            sub: begin
                lin_re = part_t'(a1[cplx_width-1 -: part_width])
                       - part_t'(b1[cplx_width-1 -: part_width]);
                lin_im = part_t'(a1[part_width-1:0]) - part_t'(b1[part_width-1:0]);
            end
            default: begin   // pass a through for out
                lin_re = a1[cplx_width-1 -: part_width];
                lin_im = a1[part_width-1:0];
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            v2 <= 1'b0;
        end else begin
            v2 <= v1;
        end
        op2  <= op1;
        dst2 <= dst1;
        if (op1 == mul || op1 == cmul) begin
            s2_re <= p_rr - p_ii;   // b_im already negated for cmul
            s2_im <= p_ri + p_ir;
        end else begin
            s2_re <= lin_re;        // sign extended, low half used
            s2_im <= lin_im;
        end
    end

    ///////////////////////////////
    // stage 3, scale and select
    ///////////////////////////////
    logic signed [sum_width-1:0] sh_re, sh_im;
    cplx_t result;

    assign sh_re  = s2_re >>> frac_bits;   // truncates toward -inf
    assign sh_im  = s2_im >>> frac_bits;
    assign result = (op2 == mul || op2 == cmul) ?
                    {sh_re[part_width-1:0], sh_im[part_width-1:0]} :
                    {s2_re[part_width-1:0], s2_im[part_width-1:0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            wb.wb_v  <= 1'b0;
            wb.out_v <= 1'b0;
        end else begin
            wb.wb_v  <= v2 && (op2 inside {add, sub, mul, cmul});
            wb.out_v <= v2 && (op2 == out);
        end
        wb.wb_dst  <= dst2;
        wb.wb_data <= result;
    end

endmodule

// File: source/pe_simd.sv
`timescale 1ns/10ps

module pe_simd (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic               inst_in_v,
    input  pe_simd_pkg::inst_t inst_in,
    input  logic               din_v,
    input  pe_simd_pkg::cplx_t din_pe,
    output logic               busy,
    output logic               done,
    output logic               dout_v,
    output pe_simd_pkg::cplx_t dout_pe
);
    import pe_simd_pkg::*;

    pc_t   pc;
    inst_t inst;        // fetched word
    cplx_t rdata_a;     // operands into the alu
    cplx_t rdata_b;

    pe_issue_if issue_bus ();
    pe_wb_if    wb_bus ();

    ///////////////////////////////
    // blocks
    ///////////////////////////////
    inst_mem u_imem (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .busy      (busy),
        .inst_in_v (inst_in_v),
        .inst_in   (inst_in),
        .pc        (pc),
        .inst      (inst)
    );

    pe_control u_ctrl (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .inst  (inst),
        .pc    (pc),
        .busy  (busy),
        .done  (done),
        .issue (issue_bus.control),
        .wb    (wb_bus.ctrl)
    );

    data_mem u_dmem (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .busy    (busy),
        .din_v   (din_v),
        .din_pe  (din_pe),
        .issue   (issue_bus.mem),
        .wb      (wb_bus.mem),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    complex_alu u_alu (
        .clk     (clk),
        .reset   (reset),
        .issue   (issue_bus.alu),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .wb      (wb_bus.alu)
    );

    // out results leave on the shared result bus
    assign dout_v  = wb_bus.out_v;
    assign dout_pe = wb_bus.wb_data;

endmodule

// File: tests/pe_simd_tb.sv
`timescale 1ns/10ps

module pe_simd_tb;
    import pe_simd_pkg::*;

    localparam int total_words     = 65;                    // program words over all runs
    localparam int watchdog_cycles = 40 * total_words + 200;

    logic  clk;
    logic  reset;
    logic  start;
    logic  inst_in_v;
    inst_t inst_in;
    logic  din_v;
    cplx_t din_pe;
    logic  busy;
    logic  done;
    logic  dout_v;
    cplx_t dout_pe;

    logic [15:0] lfsr;              // fibonacci, x^16+x^14+x^13+x^11
    cplx_t       model_regs [16];   // reference register file
    inst_t       prog [$];          // program of the current run
    cplx_t       exp_q [$];         // expected dout_pe in order
    cplx_t       exp_val;
    int          start_count;
    int          done_count;

    pe_simd UUT (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .inst_in_v (inst_in_v),
        .inst_in   (inst_in),
        .din_v     (din_v),
        .din_pe    (din_pe),
        .busy      (busy),
        .done      (done),
        .dout_v    (dout_v),
        .dout_pe   (dout_pe)
    );

    always #20 clk = ~clk;   // 40 ns period

    //////////////////////////////
    // helpers
    //////////////////////////////
    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};   // one step per bit
        end
        return v;
    endfunction

    function automatic inst_t make_inst(input opcode_t op, input int d, input int a, input int b);
        return {op, 4'(d), 4'(a), 4'(b)};
    endfunction

    function automatic inst_t emit_inst(input int r);
        return make_inst(out, r, r, r);   // dst and b only matter for the hazard check
    endfunction

    // q1.15 arithmetic, products >>> 15 truncated, sums wrap
    function automatic cplx_t alu_model(input opcode_t op, input cplx_t a, input cplx_t b);
        longint ar, ai, br, bi, re, im;
        ar = part_t'(a[31:16]);
        ai = part_t'(a[15:0]);
        br = part_t'(b[31:16]);
        bi = part_t'(b[15:0]);
        case (op)
            add: begin
                re = ar + br;
                im = ai + bi;
            end
            sub: begin
                re = ar - br;
                im = ai - bi;
            end
            mul: begin
                re = (ar * br - ai * bi) >>> 15;
                im = (ar * bi + ai * br) >>> 15;
            end
            cmul: begin   // a * conj(b)
                re = (ar * br + ai * bi) >>> 15;
                im = (ai * br - ar * bi) >>> 15;
            end
            default: begin
                re = ar;
                im = ai;
            end
        endcase
        return {re[15:0], im[15:0]};   // low 16 bits, wrap
    endfunction

    task automatic fill_random();
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = rand_bits(32);
        end
    endtask

    // one out per word queued so far, emitting its destination
    task automatic append_emits();
        int n;
        n = prog.size();
        for (int i = 0; i < n; i++) begin
            prog.push_back(emit_inst(prog[i][11:8]));
        end
    endtask

    //////////////////////////////
    // loading and running
    //////////////////////////////
    task automatic load_regs(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            din_v  = 1'b1;
            din_pe = model_regs[i];
        end
        @(negedge clk);
        din_v = 1'b0;
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            @(negedge clk);
            inst_in_v = 1'b1;
            inst_in   = prog[i];
        end
        @(negedge clk);
        inst_in_v = 1'b0;
    endtask

    // walks the program in order, queues every out value
    task automatic predict_program();
        opcode_t op;
        inst_t   w;
        foreach (prog[i]) begin
            w  = prog[i];
            op = opcode_t'(w[15:12]);
            if (op == halt) break;
            if (op inside {add, sub, mul, cmul}) begin
                model_regs[w[11:8]] = alu_model(op, model_regs[w[7:4]], model_regs[w[3:0]]);
            end else if (op == out) begin
                exp_q.push_back(model_regs[w[7:4]]);
            end
        end
    endtask

    task automatic run_program(input bit spam);
        bit finished;
        finished = 1'b0;
        @(negedge clk);
        start = 1'b1;
        start_count++;
        @(negedge clk);
        start = 1'b0;
        while (!finished) begin
            if (done) begin
                assert (!busy) else report_fail($sformatf("ERR %0t: busy high with done", $time));
                din_v     = 1'b0;   // stop junk before loads open up again
                inst_in_v = 1'b0;
                finished  = 1'b1;
            end else begin
                assert (busy) else report_fail($sformatf("ERR %0t: busy low before done", $time));
                if (spam) begin   // junk loads, must be ignored
                    din_v     = lfsr_bit();
                    din_pe    = rand_bits(32);
                    inst_in_v = lfsr_bit();
                    inst_in   = inst_t'(rand_bits(16));
                end
                @(negedge clk);
            end
        end
        repeat (8) @(negedge clk);   // quiet tail, no dout_v or second done
        assert (done_count == start_count)
            else report_fail($sformatf("ERR %0t: %0d done pulses for %0d starts",
                                       $time, done_count, start_count));
        assert (exp_q.size() == 0)
            else report_fail($sformatf("ERR %0t: %0d results never came out",
                                       $time, exp_q.size()));
    endtask

    task automatic prepare_and_run(input bit spam);
        load_regs(16);
        load_program();
        predict_program();
        run_program(spam);
    endtask

    //////////////////////////////
    // checkers
    //////////////////////////////
    always @(negedge clk) begin
        if (!reset && dout_v) begin
            assert (exp_q.size() != 0) else report_fail("dout_v pulsed with no result expected");
            exp_val = exp_q.pop_front();
            assert (dout_pe == exp_val)
                else report_fail($sformatf("ERR %0t: dout_pe %h, expected %h",
                                           $time, dout_pe, exp_val));
        end
        if (!reset && done) begin
            done_count++;
        end
    end

    assert property (@(posedge clk) disable iff (reset) dout_v |-> busy)
        else report_fail($sformatf("ERR %0t: dout_v outside a run", $time));
    assert property (@(posedge clk) disable iff (reset) done |-> !busy)
        else report_fail($sformatf("ERR %0t: busy still high at done", $time));

    // watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        report_fail("timeout, the testbench did not finish in the expected number of cycles");
    end

    //////////////////////////////
    // programs
    //////////////////////////////
    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        start       = 1'b0;
        inst_in_v   = 1'b0;
        inst_in     = '0;
        din_v       = 1'b0;
        din_pe      = '0;
        lfsr        = 16'd55437;
        start_count = 0;
        done_count  = 0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        assert (!busy && !done && !dout_v)
            else report_fail($sformatf("ERR %0t: outputs not idle after reset", $time));

        // emit every register in order
        fill_random();
        prog.delete();
        for (int i = 0; i < 16; i++) prog.push_back(emit_inst(i));
        prog.push_back(make_inst(halt, 0, 0, 0));
        prepare_and_run(1'b0);

        // add and sub with wrap
        fill_random();
        model_regs[0] = 32'h7fff_7fff;
        model_regs[1] = 32'h0001_0001;
        model_regs[2] = 32'h8000_8000;
        model_regs[3] = 32'h0001_0001;
        prog.delete();
        prog.push_back(make_inst(add, 4, 0, 1));
        prog.push_back(make_inst(sub, 5, 2, 3));
        prog.push_back(make_inst(add, 6, 7, 8));
        prog.push_back(make_inst(sub, 9, 10, 11));
        prog.push_back(make_inst(add, 12, 12, 13));   // dst is also a source
        append_emits();
        prog.push_back(make_inst(halt, 0, 0, 0));
        prepare_and_run(1'b0);

        // mul and cmul, -1.0 in either part
        fill_random();
        model_regs[0] = 32'h8000_8000;
        model_regs[1] = 32'h8000_8000;
        model_regs[2] = 32'h8000_1234;
        model_regs[3] = 32'h4000_8000;
        prog.delete();
        prog.push_back(make_inst(mul, 4, 0, 1));
        prog.push_back(make_inst(cmul, 5, 0, 1));
        prog.push_back(make_inst(mul, 6, 2, 3));
        prog.push_back(make_inst(cmul, 7, 2, 3));
        prog.push_back(make_inst(cmul, 8, 3, 2));
        prog.push_back(make_inst(mul, 9, 10, 11));
        prog.push_back(make_inst(cmul, 12, 13, 14));
        append_emits();
        prog.push_back(make_inst(halt, 0, 0, 0));
        prepare_and_run(1'b0);

        // dependent chain with independent work in between
        fill_random();
        prog.delete();
        prog.push_back(make_inst(mul, 1, 0, 2));
        prog.push_back(emit_inst(1));                 // waits on r1
        prog.push_back(make_inst(add, 9, 10, 11));
        prog.push_back(make_inst(add, 3, 1, 4));
        prog.push_back(make_inst(sub, 12, 13, 14));
        prog.push_back(make_inst(cmul, 5, 3, 6));
        prog.push_back(make_inst(mul, 15, 9, 12));
        prog.push_back(make_inst(sub, 7, 5, 8));
        prog.push_back(make_inst(nop, 0, 0, 0));
        prog.push_back(emit_inst(7));
        prog.push_back(emit_inst(15));
        prog.push_back(make_inst(halt, 0, 0, 0));
        prepare_and_run(1'b0);

        // junk loads while busy, then reload at address 0
        fill_random();
        prog.delete();
        prog.push_back(make_inst(add, 4, 0, 1));
        prog.push_back(make_inst(mul, 5, 2, 3));
        prog.push_back(emit_inst(4));
        prog.push_back(emit_inst(5));
        prog.push_back(make_inst(halt, 0, 0, 0));
        prepare_and_run(1'b1);
        for (int i = 0; i < 4; i++) model_regs[i] = rand_bits(32);
        prog.delete();
        prog.push_back(make_inst(cmul, 6, 0, 5));   // r5 left over from the last run
        prog.push_back(emit_inst(6));
        prog.push_back(emit_inst(4));
        prog.push_back(emit_inst(1));
        prog.push_back(make_inst(halt, 0, 0, 0));
        load_regs(4);
        load_program();
        predict_program();
        run_program(1'b0);

        if (exp_q.size() == 0 && done_count == start_count) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            report_fail("final bookkeeping does not match the runs");
        end
    end

endmodule

// File: pe_simd.f
source/pe_simd_pkg.sv
source/pe_ifs.sv
source/inst_mem.sv
source/pe_control.sv
source/data_mem.sv
source/complex_alu.sv
source/pe_simd.sv
tests/pe_simd_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the pe_simd testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f pe_simd.f --top-module pe_simd_tb -o sim_pe_simd

# a failing run exits non-zero, the search below decides
output=$(./obj_dir/sim_pe_simd 2>&1) || true
echo "$output"

if grep -qF "Result: PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi
